/* hdl/exe_pkg.sv */
/*
   Execute stage package
   Widths, instruction group and operation enums, and the decode,
   forwarding, unit output and result records of the RV32I execute stage
*/
`default_nettype none

package exe_pkg;

   // --------------------
   // widths with a meaning
   typedef logic [31:0]   word_t;          // data word
   typedef logic [31:0]   pc_t;            // instruction address
   typedef logic [4:0]    reg_addr_t;      // gpr index
   typedef word_t [31:0]  gpr_file_t;      // whole register file, entry 0 is x0

   // --------------------
   // encodings
   typedef enum logic [2:0]
   {
      IG_ALU, IG_BR, IG_LD, IG_ST, IG_ILL
   } ig_type_e;                            // instruction group from decode

   typedef enum logic [3:0]
   {
      ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
   } alu_op_e;

   typedef enum logic [1:0]
   {
      B_COND, B_JAL, B_JALR
   } br_op_e;

   typedef enum logic [1:0]
   {
      X_RS1, X_PC, X_ZERO                  // X_PC for AUIPC, X_ZERO for LUI
   } sel_x_e;

   typedef enum logic
   {
      Y_RS2, Y_IMM
   } sel_y_e;

   typedef enum logic [1:0]
   {
      SZ_B, SZ_H, SZ_W
   } ls_size_e;

   // --------------------
   // records
   typedef struct packed {
      pc_t        pc;
      logic       ci;                      // 16 bit instruction
      ig_type_e   ig_type;
      logic [3:0] op;                      // alu_op_e or br_op_e by group
      logic [2:0] funct3;
      word_t      imm;                     // sign extended immediate
      sel_x_e     sel_x;
      sel_y_e     sel_y;
      reg_addr_t  rd_addr;
      reg_addr_t  rs1_addr;
      reg_addr_t  rs2_addr;
      logic       rd_wr;
      logic       rs1_rd;
      logic       rs2_rd;
      pc_t        predicted_addr;          // next pc guessed by fetch
   } dec_instr_t;

   typedef struct packed {
      logic       valid;
      logic       rd_wr;
      reg_addr_t  rd_addr;
      word_t      rd_data;
   } fwd_gpr_t;                            // 39 bits from mem or wb stage

   typedef struct packed {
      pc_t        pc;
      ig_type_e   ig_type;
      logic       rd_wr;
      reg_addr_t  rd_addr;
      word_t      rd_data;
      logic       is_ld;
      logic       is_st;
      word_t      ls_addr;
      word_t      st_data;
      ls_size_e   size;
      logic       zero_ext;                // LBU and LHU
      logic       mispre;                  // fetch was reloaded
      logic       instr_err;
      pc_t        br_pc;                   // misaligned branch target
   } exe_result_t;

   typedef struct packed {
      word_t      result;
      word_t      ls_addr;
      word_t      st_data;
      ls_size_e   size;
      logic       zero_ext;
      logic       mis;                     // misaligned address or target
      pc_t        taken_pc;
      pc_t        link_pc;
   } unit_out_t;

endpackage

`default_nettype wire

/* hdl/operand_fwd.sv */
/*
   Operand forwarding
   Reads rs1 and rs2 from the register file and replaces them with
   newer values from the memory or write-back stage. Memory stage wins
*/
`timescale 1ns/100ps
`default_nettype none

module operand_fwd
(
   input  var exe_pkg::gpr_file_t   gpr,        // register file contents
   input  var exe_pkg::dec_instr_t  dec_data,   // decoded instruction
   input  var exe_pkg::fwd_gpr_t    fwd_mem,    // result in memory stage
   input  var exe_pkg::fwd_gpr_t    fwd_wb,     // result in write-back stage
   output exe_pkg::word_t           rs1_val,
   output exe_pkg::word_t           rs2_val
);
   import exe_pkg::*;

   // record carries a newer value for this source
   function automatic logic fwd_hit
   (
      input fwd_gpr_t  rec,
      input logic      src_rd,
      input reg_addr_t src_addr
   );
      return src_rd & rec.valid & rec.rd_wr &
             (rec.rd_addr == src_addr) & (src_addr != '0);   // x0 never forwarded
   endfunction

   always_comb
   begin
      // --------------------
      // rs1
      if (fwd_hit(fwd_mem, dec_data.rs1_rd, dec_data.rs1_addr))
         rs1_val = fwd_mem.rd_data;                          // most recent first
      else if (fwd_hit(fwd_wb, dec_data.rs1_rd, dec_data.rs1_addr))
         rs1_val = fwd_wb.rd_data;
      else
         rs1_val = gpr[dec_data.rs1_addr];

      // --------------------
      // rs2
      if (fwd_hit(fwd_mem, dec_data.rs2_rd, dec_data.rs2_addr))
         rs2_val = fwd_mem.rd_data;
      else if (fwd_hit(fwd_wb, dec_data.rs2_rd, dec_data.rs2_addr))
         rs2_val = fwd_wb.rd_data;
      else
         rs2_val = gpr[dec_data.rs2_addr];
   end

endmodule

`default_nettype wire

/* hdl/int_unit.sv */
/*
   Integer unit
   ALU for register and immediate forms, LUI and AUIPC through the
   operand selects, and load/store address generation with access size
   and misalignment check. Single cycle, purely combinational
*/
`timescale 1ns/100ps
`default_nettype none

module int_unit
#(
   parameter bit COMPRESSED = 1'b0                 // 16 bit instructions present
)
(
   input  var exe_pkg::dec_instr_t  dec_data,      // decoded instruction
   input  var exe_pkg::word_t       rs1_val,       // rs1 after forwarding
   input  var exe_pkg::word_t       rs2_val,       // rs2 after forwarding
   output exe_pkg::unit_out_t       int_out
);
   import exe_pkg::*;

   word_t      x_op;                               // alu operand x
   word_t      y_op;                               // alu operand y
   logic [4:0] shamt;
   word_t      alu_res;
   word_t      ls_addr;
   ls_size_e   ls_size;
   logic       ls_zext;
   logic       ls_mis;
   pc_t        seq_pc;                             // fall-through fetch address

   // --------------------
   // operand selects
   always_comb
   begin
      case (dec_data.sel_x)
         X_RS1:   x_op = rs1_val;
         X_PC:    x_op = dec_data.pc;              // AUIPC
         default: x_op = '0;                       // LUI adds imm to zero
      endcase
      y_op = (dec_data.sel_y == Y_IMM) ? dec_data.imm : rs2_val;
   end

   assign shamt = y_op[4:0];                       // only low 5 bits shift

   // --------------------
   // alu
   always_comb
   begin
      case (alu_op_e'(dec_data.op))
         ADD:     alu_res = x_op + y_op;
         SUB:     alu_res = x_op - y_op;
         SLL:     alu_res = x_op << shamt;
         SLT:     alu_res = {31'b0, $signed(x_op) < $signed(y_op)};
         SLTU:    alu_res = {31'b0, x_op < y_op};
         XOR:     alu_res = x_op ^ y_op;
         SRL:     alu_res = x_op >> shamt;
         SRA:     alu_res = $signed(x_op) >>> shamt;   // sign fill
         OR:      alu_res = x_op | y_op;
         AND:     alu_res = x_op & y_op;
         default: alu_res = '0;
      endcase
   end

   // --------------------
   // load/store address, size and alignment
   assign ls_addr = rs1_val + dec_data.imm;

   always_comb
   begin
      ls_zext = 1'b0;
      case (dec_data.funct3)
         3'd0:    ls_size = SZ_B;                  // LB, SB
         3'd1:    ls_size = SZ_H;                  // LH, SH
         3'd4:
         begin
            ls_size = SZ_B;                        // LBU
            ls_zext = 1'b1;
         end
         3'd5:
         begin
            ls_size = SZ_H;                        // LHU
            ls_zext = 1'b1;
         end
         default: ls_size = SZ_W;                  // LW, SW
      endcase

      ls_mis = ((ls_size == SZ_H) && ls_addr[0]) ||
               ((ls_size == SZ_W) && (ls_addr[1:0] != 2'b00));
   end

   // next sequential pc, ci only shortens it on a compressed core
   assign seq_pc = dec_data.pc + ((COMPRESSED && dec_data.ci) ? 32'd2 : 32'd4);

   always_comb
   begin
      int_out.result   = alu_res;
      int_out.ls_addr  = ls_addr;
      int_out.st_data  = rs2_val;                  // stored as read
      int_out.size     = ls_size;
      int_out.zero_ext = ls_zext;
      int_out.mis      = ls_mis;
      int_out.taken_pc = seq_pc;                   // no control transfer here
      int_out.link_pc  = seq_pc;
   end

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
/*
   Branch unit
   Conditional compare, JAL and JALR targets, link address, target
   alignment check and detection of a wrong fetch prediction
*/
`timescale 1ns/100ps
`default_nettype none

module branch_unit
#(
   parameter bit COMPRESSED = 1'b0                 // halfword targets legal
)
(
   input  var exe_pkg::dec_instr_t  dec_data,      // decoded instruction
   input  var exe_pkg::word_t       rs1_val,
   input  var exe_pkg::word_t       rs2_val,
   output exe_pkg::unit_out_t       br_out,
   output logic                     br_mispre      // fetch went the wrong way
);
   import exe_pkg::*;

   logic  cond_true;                               // compare result
   pc_t   link_pc;
   pc_t   br_tgt;                                  // pc relative target
   pc_t   taken_pc;
   logic  tgt_mis;

   // --------------------
   // compare by funct3
   always_comb
   begin
      case (dec_data.funct3)
         3'd0:    cond_true = (rs1_val == rs2_val);                     // BEQ
         3'd1:    cond_true = (rs1_val != rs2_val);                     // BNE
         3'd4:    cond_true = ($signed(rs1_val) <  $signed(rs2_val));   // BLT
         3'd5:    cond_true = ($signed(rs1_val) >= $signed(rs2_val));   // BGE
         3'd6:    cond_true = (rs1_val <  rs2_val);                     // BLTU
         3'd7:    cond_true = (rs1_val >= rs2_val);                     // BGEU
         default: cond_true = 1'b0;
      endcase
   end

   assign link_pc = dec_data.pc + ((COMPRESSED && dec_data.ci) ? 32'd2 : 32'd4);
   assign br_tgt  = dec_data.pc + dec_data.imm;

   // --------------------
   // where fetch should go
   always_comb
   begin
      case (br_op_e'(dec_data.op))
         B_COND:  taken_pc = cond_true ? br_tgt : link_pc;
         B_JAL:   taken_pc = br_tgt;
         B_JALR:  taken_pc = (rs1_val + dec_data.imm) & ~32'd1;   // bit 0 dropped
         default: taken_pc = link_pc;
      endcase
   end

   // only word targets are legal without the C extension
   assign tgt_mis   = !COMPRESSED && taken_pc[1];
   assign br_mispre = !tgt_mis && (dec_data.predicted_addr != taken_pc);

   always_comb
   begin
      br_out          = '0;                        // no load/store fields
      br_out.result   = link_pc;
      br_out.mis      = tgt_mis;
      br_out.taken_pc = taken_pc;
      br_out.link_pc  = link_pc;                   // rd value of JAL/JALR
   end

endmodule

`default_nettype wire

/* hdl/result_select.sv */
/*
   Result select
   Picks the unit output by instruction group, reloads fetch on a wrong
   prediction and keeps the one-entry pipe register to the memory stage
   with valid/ready handshakes on both sides
*/
`timescale 1ns/100ps
`default_nettype none

module result_select
(
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      cpu_halt,      // stop taking instructions
   input  wire                      pipe_flush,    // drop the held result
   input  wire                      dec_valid,
   input  var exe_pkg::dec_instr_t  dec_data,
   input  var exe_pkg::unit_out_t   int_out,
   input  var exe_pkg::unit_out_t   br_out,
   input  wire                      br_mispre,
   input  wire                      mem_rdy,
   output logic                     dec_rdy,
   output logic                     rld_pc_flag,   // fetch reload strobe
   output exe_pkg::pc_t             rld_pc_addr,
   output logic                     mem_valid,
   output exe_pkg::exe_result_t     mem_data
);
   import exe_pkg::*;

   logic        pipe_full;
   logic        xfer_in;                           // taken from decode
   logic        xfer_out;                          // taken by memory stage
   logic        rd_wr_ok;                          // rd write with x0 masked
   logic        reload;
   exe_result_t exe_dout;

   // --------------------
   // handshakes
   assign dec_rdy   = rst_n & !cpu_halt & (!pipe_full | xfer_out);
   assign xfer_in   = dec_valid & dec_rdy;
   assign xfer_out  = mem_valid & mem_rdy;
   assign mem_valid = pipe_full;

   assign rd_wr_ok  = dec_data.rd_wr & (dec_data.rd_addr != '0);

   // --------------------
   // result by group
   always_comb
   begin
      exe_dout         = '0;
      reload           = 1'b0;
      rld_pc_addr      = br_out.taken_pc;
      exe_dout.pc      = dec_data.pc;
      exe_dout.ig_type = dec_data.ig_type;
      exe_dout.rd_addr = dec_data.rd_addr;

      case (dec_data.ig_type)
         IG_ALU:
         begin
            exe_dout.rd_wr   = rd_wr_ok;
            exe_dout.rd_data = int_out.result;
         end
         IG_BR:
         begin
            if (br_out.mis)                               // trap taken later in the pipe
            begin
               exe_dout.instr_err = 1'b1;
               exe_dout.br_pc     = br_out.taken_pc;
            end
            else if (br_mispre)
            begin
               exe_dout.mispre = 1'b1;
               reload          = 1'b1;                   // younger fetches are wrong
            end
            else if (br_op_e'(dec_data.op) != B_COND)
            begin
               exe_dout.rd_wr   = rd_wr_ok;              // JAL, JALR link
               exe_dout.rd_data = br_out.link_pc;
            end
         end
         IG_LD:
         begin
            exe_dout.rd_wr     = rd_wr_ok;               // data arrives in mem stage
            exe_dout.is_ld     = 1'b1;
            exe_dout.ls_addr   = int_out.ls_addr;
            exe_dout.size      = int_out.size;
            exe_dout.zero_ext  = int_out.zero_ext;
            exe_dout.instr_err = int_out.mis;
         end
         IG_ST:
         begin
            exe_dout.is_st     = 1'b1;
            exe_dout.ls_addr   = int_out.ls_addr;
            exe_dout.st_data   = int_out.st_data;
            exe_dout.size      = int_out.size;
            exe_dout.instr_err = int_out.mis;
         end
         default: exe_dout.instr_err = 1'b1;             // IG_ILL and unused codes
      endcase

      rld_pc_flag = xfer_in & reload;                    // one strobe per accepted branch
   end

   // --------------------
   // pipe register
   always_ff @(posedge clk)
   begin
      if (!rst_n || pipe_flush)
         pipe_full <= 1'b0;
      else if (xfer_in)
         pipe_full <= 1'b1;                              // refill even while draining
      else if (xfer_out)
         pipe_full <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (xfer_in)
         mem_data <= exe_dout;
   end

   // held result must not change under back-pressure
   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mem_valid && !mem_rdy && !pipe_flush |=> mem_valid && $stable(mem_data));

   // a reload belongs to an instruction that lands in the pipe register
   a_rld_accept: assert property (@(posedge clk) disable iff (!rst_n)
      rld_pc_flag && !pipe_flush |=> mem_valid && mem_data.mispre);

endmodule

`default_nettype wire

/* hdl/exe_stage.sv */
/*
   RV32I execute stage
   Operand forwarding, integer and branch units side by side, and the
   result select with the pipe register to the memory stage
*/
`timescale 1ns/100ps
`default_nettype none

module exe_stage
#(
   parameter bit COMPRESSED = 1'b0                 // 1 when the C extension is on
)
(
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      cpu_halt,
   input  wire                      pipe_flush,
   // decode side
   input  wire                      dec_valid,
   input  var exe_pkg::dec_instr_t  dec_data,
   output logic                     dec_rdy,
   // register file and forwarding
   input  var exe_pkg::gpr_file_t   gpr,
   input  var exe_pkg::fwd_gpr_t    fwd_mem,
   input  var exe_pkg::fwd_gpr_t    fwd_wb,
   // fetch reload
   output logic                     rld_pc_flag,
   output exe_pkg::pc_t             rld_pc_addr,
   // memory side
   output logic                     mem_valid,
   output exe_pkg::exe_result_t     mem_data,
   input  wire                      mem_rdy
);
   import exe_pkg::*;

   word_t     rs1_val;                             // forwarded operands
   word_t     rs2_val;
   unit_out_t int_out;
   unit_out_t br_out;
   logic      br_mispre;

   operand_fwd operand_fwd_i
   (
      .gpr(gpr), .dec_data(dec_data), .fwd_mem(fwd_mem), .fwd_wb(fwd_wb),
      .rs1_val(rs1_val), .rs2_val(rs2_val)
   );

   int_unit #(.COMPRESSED(COMPRESSED)) int_unit_i
   (
      .dec_data(dec_data), .rs1_val(rs1_val), .rs2_val(rs2_val), .int_out(int_out)
   );

   branch_unit #(.COMPRESSED(COMPRESSED)) branch_unit_i
   (
      .dec_data(dec_data), .rs1_val(rs1_val), .rs2_val(rs2_val),
      .br_out(br_out), .br_mispre(br_mispre)
   );

   result_select result_select_i
   (
      .clk(clk), .rst_n(rst_n), .cpu_halt(cpu_halt), .pipe_flush(pipe_flush),
      .dec_valid(dec_valid), .dec_data(dec_data), .int_out(int_out), .br_out(br_out),
      .br_mispre(br_mispre), .mem_rdy(mem_rdy), .dec_rdy(dec_rdy),
      .rld_pc_flag(rld_pc_flag), .rld_pc_addr(rld_pc_addr),
      .mem_valid(mem_valid), .mem_data(mem_data)
   );

endmodule

`default_nettype wire

/* verif/exe_stage_tb.sv */
/*
   Execute stage testbench
   Replays the instruction lines of the test data file through the stage,
   checks the result record and fetch reload, then halt and flush
*/
`timescale 1ns/100ps
`default_nettype none

module exe_stage_tb;
   import exe_pkg::*;

   localparam int WORDS      = 30;                 // hex words per data line
   localparam int MAX_TESTS  = 64;
   localparam int CLK_PERIOD = 8;
   localparam int WAIT_MAX   = 20;                 // cycles to wait for dec_rdy
   localparam int CW         = $bits(exe_result_t);   // compare width

   logic        clk = 1'b0;
   logic        rst_n;
   logic        cpu_halt;
   logic        pipe_flush;
   logic        dec_valid;
   dec_instr_t  dec_data;
   logic        dec_rdy;
   gpr_file_t   gpr;
   fwd_gpr_t    fwd_mem;
   fwd_gpr_t    fwd_wb;
   logic        rld_pc_flag;
   pc_t         rld_pc_addr;
   logic        mem_valid;
   exe_result_t mem_data;
   logic        mem_rdy;

   logic [31:0] td [0:WORDS*MAX_TESTS-1];          // test data words
   int          n_tests;

   always #(CLK_PERIOD/2) clk = ~clk;

   exe_stage #(.COMPRESSED(1'b0)) exe_stage_i
   (
      .clk(clk), .rst_n(rst_n), .cpu_halt(cpu_halt), .pipe_flush(pipe_flush),
      .dec_valid(dec_valid), .dec_data(dec_data), .dec_rdy(dec_rdy),
      .gpr(gpr), .fwd_mem(fwd_mem), .fwd_wb(fwd_wb),
      .rld_pc_flag(rld_pc_flag), .rld_pc_addr(rld_pc_addr),
      .mem_valid(mem_valid), .mem_data(mem_data), .mem_rdy(mem_rdy)
   );

   // --------------------
   // helpers
   task automatic check_value(input string name, input logic [CW-1:0] exp,
                              input logic [CW-1:0] act);
      if (exp !== act)
      begin
         $display("ERROR %s expected %h actual %h", name, exp, act);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   // access size of a load or store from funct3
   function automatic ls_size_e ls_size_of(input logic [2:0] f3);
      case (f3)
         3'd0, 3'd4: return SZ_B;                  // LB, LBU, SB
         3'd1, 3'd5: return SZ_H;                  // LH, LHU, SH
         default:    return SZ_W;
      endcase
   endfunction

   task automatic drive_line(input int b);         // call right after a rising edge
      dec_instr_t d;
      fwd_gpr_t   fm;
      fwd_gpr_t   fw;
      d.pc       = td[b];
      d.ci       = td[b+1][0];
      d.ig_type  = ig_type_e'(td[b+2][2:0]);
      d.op       = td[b+3][3:0];
      d.funct3   = td[b+4][2:0];
      d.imm      = td[b+5];
      d.sel_x    = sel_x_e'(td[b+6][1:0]);
      d.sel_y    = sel_y_e'(td[b+7][0]);
      d.rd_addr  = td[b+8][4:0];
      d.rs1_addr = td[b+9][4:0];
      d.rs2_addr = td[b+10][4:0];
      d.rd_wr    = td[b+11][0];
      d.rs1_rd   = td[b+12][0];
      d.rs2_rd   = td[b+13][0];
      d.predicted_addr = td[b+14];
      fm = {td[b+15][0], td[b+16][0], td[b+17][4:0], td[b+18]};
      fw = {td[b+19][0], td[b+20][0], td[b+21][4:0], td[b+22]};
      dec_data  <= d;
      fwd_mem   <= fm;
      fwd_wb    <= fw;
      dec_valid <= 1'b1;
   endtask

   // returns at a falling edge with dec_rdy high, so the next edge accepts
   task automatic wait_accept(input string name);
      int n;
      n = 0;
      @(negedge clk);
      while (!dec_rdy)
      begin
         n++;
         if (n > WAIT_MAX)
         begin
            $display("dec_rdy never came up for %s", name);
            $display("ERRORS FOUND");
            $fatal(1);
         end
         @(negedge clk);
      end
   endtask

   task automatic run_test(input int t);
      int          b;
      int          stall;
      string       name;
      exe_result_t held;
      ig_type_e    grp;
      logic        exp_zext;
      b     = t * WORDS;
      name  = $sformatf("test %0d pc %h", t, td[b]);
      grp   = ig_type_e'(td[b+2][2:0]);
      stall = td[b+23][0] ? int'($urandom_range(3, 1)) : 0;
      repeat ($urandom_range(2, 0)) @(posedge clk);   // idle gap
      @(posedge clk);
      drive_line(b);
      wait_accept(name);
      check_value({name, " rld_pc_flag"}, CW'(td[b+27][0]), CW'(rld_pc_flag));
      if (td[b+27][0])
         check_value({name, " rld_pc_addr"}, CW'(td[b+29]), CW'(rld_pc_addr));
      @(posedge clk);                               // accepted here
      dec_valid <= 1'b0;
      if (stall > 0)
         mem_rdy <= 1'b0;
      @(negedge clk);
      check_value({name, " mem_valid"}, CW'(1), CW'(mem_valid));
      check_value({name, " pc"}, CW'(td[b]), CW'(mem_data.pc));
      check_value({name, " rd_wr"}, CW'(td[b+24][0]), CW'(mem_data.rd_wr));
      check_value({name, " rd_data"}, CW'(td[b+25]), CW'(mem_data.rd_data));
      check_value({name, " ls_addr"}, CW'(td[b+26]), CW'(mem_data.ls_addr));
      check_value({name, " mispre"}, CW'(td[b+27][0]), CW'(mem_data.mispre));
      check_value({name, " instr_err"}, CW'(td[b+28][0]), CW'(mem_data.instr_err));
      check_value({name, " is_ld"}, CW'(grp == IG_LD), CW'(mem_data.is_ld));
      check_value({name, " is_st"}, CW'(grp == IG_ST), CW'(mem_data.is_st));
      if (grp == IG_LD || grp == IG_ST)
      begin
         exp_zext = (grp == IG_LD) && (td[b+4][2:0] inside {3'd4, 3'd5});  // LBU, LHU
         check_value({name, " size"}, CW'(ls_size_of(td[b+4][2:0])), CW'(mem_data.size));
         check_value({name, " zero_ext"}, CW'(exp_zext), CW'(mem_data.zero_ext));
      end
      held = mem_data;
      repeat (stall)                                // memory stage stalls
      begin
         @(negedge clk);
         check_value({name, " stall mem_valid"}, CW'(1), CW'(mem_valid));
         check_value({name, " stall dec_rdy"}, CW'(0), CW'(dec_rdy));
         check_value({name, " stall mem_data"}, CW'(held), CW'(mem_data));
      end
      if (stall > 0)
      begin
         @(posedge clk);
         mem_rdy <= 1'b1;
      end
   endtask

   // --------------------
   // main sequence
   initial
   begin
      void'($urandom(32'hb29a_0c48));
      rst_n      = 1'b0;
      cpu_halt   = 1'b0;
      pipe_flush = 1'b0;
      dec_valid  = 1'b0;
      dec_data   = '0;
      fwd_mem    = '0;
      fwd_wb     = '0;
      mem_rdy    = 1'b1;
      for (int i = 0; i < 32; i++)
         gpr[i] = i * 32'h0101_0101;                // x0 comes out zero

      $readmemh("verif/exe_stage_testdata.txt", td);
      n_tests = 0;
      while (n_tests < MAX_TESTS && td[n_tests*WORDS] !== 32'hffff_ffff)
         n_tests++;

      @(negedge clk);
      check_value("reset dec_rdy", CW'(0), CW'(dec_rdy));
      @(posedge clk);                               // second reset edge
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("reset mem_valid", CW'(0), CW'(mem_valid));
      check_value("reset rld_pc_flag", CW'(0), CW'(rld_pc_flag));

      for (int t = 0; t < n_tests; t++)
         run_test(t);

      // ---- halt ----
      @(posedge clk);
      cpu_halt <= 1'b1;
      drive_line(0);
      repeat (3)
      begin
         @(negedge clk);
         check_value("halt dec_rdy", CW'(0), CW'(dec_rdy));
      end
      @(posedge clk);
      cpu_halt <= 1'b0;
      wait_accept("after halt");

      // ---- flush while stalled ----
      @(posedge clk);
      dec_valid <= 1'b0;
      mem_rdy   <= 1'b0;
      @(negedge clk);
      check_value("flush mem_valid before", CW'(1), CW'(mem_valid));
      @(posedge clk);
      pipe_flush <= 1'b1;
      @(posedge clk);                               // register empties here
      pipe_flush <= 1'b0;
      @(negedge clk);
      check_value("flush mem_valid after", CW'(0), CW'(mem_valid));

      $display("NO ERRORS");
      $finish;
   end

   // watchdog allows 40 cycles per data line plus the halt and flush part
   initial
   begin
      #1;
      #((n_tests + 4) * 40 * CLK_PERIOD);
      $display("watchdog expired, the test sequence did not finish in time");
      $display("ERRORS FOUND");
      $fatal(1);
   end

endmodule

`default_nettype wire

/* exe_stage.f */
hdl/exe_pkg.sv
hdl/operand_fwd.sv
hdl/int_unit.sv
hdl/branch_unit.sv
hdl/result_select.sv
hdl/exe_stage.sv
verif/exe_stage_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = exe_stage_tb
FILELIST  = exe_stage.f
OBJDIR    = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* verif/exe_stage_testdata.txt */
// pc ci ig op f3 imm sx sy rd rs1 rs2 rdwr r1rd r2rd pred | mem v wr addr data | wb v wr addr data
// stall | exp rd_wr rd_data ls_addr mispre instr_err rld_pc_addr ; last line ffffffff ends the list
00001000 0 0 0 0 00000000 0 0 03 01 02 1 1 1 00001004 0 0 00 00000000 0 0 00 00000000 0 1 03030303 00000000 0 0 00000000
00001004 0 0 1 0 00000000 0 0 04 02 01 1 1 1 00001008 0 0 00 00000000 0 0 00 00000000 1 1 01010101 00000000 0 0 00000000
00001008 0 0 0 0 fffffff0 0 1 05 01 00 1 1 0 0000100c 0 0 00 00000000 0 0 00 00000000 0 1 010100f1 00000000 0 0 00000000
0000100c 0 0 0 0 12345000 2 1 06 00 00 1 0 0 00001010 0 0 00 00000000 0 0 00 00000000 0 1 12345000 00000000 0 0 00000000
00001010 0 0 0 0 00002000 1 1 07 00 00 1 0 0 00001014 0 0 00 00000000 0 0 00 00000000 0 1 00003010 00000000 0 0 00000000
00001014 0 0 2 1 00000000 0 0 08 03 01 1 1 1 00001018 0 0 00 00000000 0 0 00 00000000 0 1 06060606 00000000 0 0 00000000
00001018 0 0 7 5 00000004 0 1 09 0a 00 1 1 0 0000101c 1 1 0a f0000000 0 0 00 00000000 0 1 ff000000 00000000 0 0 00000000
0000101c 0 0 3 2 ffffffff 0 1 0b 01 00 1 1 0 00001020 0 0 00 00000000 0 0 00 00000000 0 1 00000000 00000000 0 0 00000000
00001020 0 0 4 3 ffffffff 0 1 0c 01 00 1 1 0 00001024 0 0 00 00000000 0 0 00 00000000 0 1 00000001 00000000 0 0 00000000
00001024 0 0 0 0 00000000 0 0 00 01 02 1 1 1 00001028 0 0 00 00000000 0 0 00 00000000 0 0 03030303 00000000 0 0 00000000
00001028 0 0 0 0 00000000 0 0 0d 05 02 1 1 1 0000102c 1 1 05 11111111 1 1 05 22222222 0 1 13131313 00000000 0 0 00000000
0000102c 0 0 0 0 00000000 0 0 0d 05 02 1 1 1 00001030 1 1 06 33333333 1 1 05 22222222 0 1 24242424 00000000 0 0 00000000
00001030 0 0 0 0 00000000 0 0 0e 00 02 1 1 1 00001034 1 1 00 deadbeef 1 1 00 deadbeef 0 1 02020202 00000000 0 0 00000000
00001034 0 0 0 0 00000000 0 0 0e 05 02 1 1 1 00001038 1 0 05 11111111 0 0 00 00000000 1 1 07070707 00000000 0 0 00000000
00001038 0 0 9 7 0000ff0f 0 1 0f 03 00 1 1 0 0000103c 0 0 00 00000000 0 0 00 00000000 0 1 00000303 00000000 0 0 00000000
00002000 0 1 0 0 00000100 0 0 00 01 01 0 1 1 00002004 0 0 00 00000000 0 0 00 00000000 0 0 00000000 00000000 1 0 00002100
00002004 0 1 0 1 00000100 0 0 00 01 01 0 1 1 00002008 0 0 00 00000000 0 0 00 00000000 0 0 00000000 00000000 0 0 00000000
00002008 0 1 0 4 fffffff8 0 0 00 0a 01 0 1 1 00002000 1 1 0a f0000000 0 0 00 00000000 0 0 00000000 00000000 0 0 00000000
0000200c 0 1 0 6 fffffff8 0 0 00 0a 01 0 1 1 00002000 1 1 0a f0000000 0 0 00 00000000 0 0 00000000 00000000 1 0 00002010
00003000 0 1 1 0 00000040 0 0 01 00 00 1 0 0 00003040 0 0 00 00000000 0 0 00 00000000 0 1 00003004 00000000 0 0 00000000
00003004 0 1 1 0 00000080 0 0 01 00 00 1 0 0 00003008 0 0 00 00000000 0 0 00 00000000 0 0 00000000 00000000 1 0 00003084
00003008 0 1 2 0 00000003 0 0 05 06 00 1 1 0 00004004 0 0 00 00000000 1 1 06 00004001 1 1 0000300c 00000000 0 0 00000000
0000300c 0 1 1 0 00000006 0 0 01 00 00 1 0 0 00003010 0 0 00 00000000 0 0 00 00000000 0 0 00000000 00000000 0 1 00000000
00003010 0 1 0 5 00000020 0 0 00 02 01 0 1 1 00003030 0 0 00 00000000 0 0 00 00000000 0 0 00000000 00000000 0 0 00000000
00004000 0 2 0 2 00000004 0 1 0f 10 00 1 1 0 00004004 1 1 10 00008000 0 0 00 00000000 0 1 00000000 00008004 0 0 00000000
00004004 0 2 0 1 00000001 0 1 0f 10 00 1 1 0 00004008 1 1 10 00008000 0 0 00 00000000 0 1 00000000 00008001 0 1 00000000
00004008 0 2 0 5 00000002 0 1 0f 10 00 1 1 0 0000400c 1 1 10 00008000 0 0 00 00000000 0 1 00000000 00008002 0 0 00000000
0000400c 0 2 0 2 00000002 0 1 0f 10 00 1 1 0 00004010 1 1 10 00008000 0 0 00 00000000 0 1 00000000 00008002 0 1 00000000
00004010 0 2 0 4 00000003 0 1 0f 10 00 1 1 0 00004014 1 1 10 00008000 0 0 00 00000000 0 1 00000000 00008003 0 0 00000000
00004014 0 3 0 2 00000008 0 1 00 10 02 0 1 1 00004018 1 1 10 00008000 0 0 00 00000000 1 0 00000000 00008008 0 0 00000000
00004018 0 3 0 1 00000005 0 1 00 10 02 0 1 1 0000401c 1 1 10 00008000 0 0 00 00000000 0 0 00000000 00008005 0 1 00000000
0000401c 0 4 0 0 00000000 0 0 00 00 00 0 0 0 00004020 0 0 00 00000000 0 0 00 00000000 0 0 00000000 00000000 0 1 00000000
ffffffff
